// File: logic/tiny_mips_pkg.sv
package tiny_mips_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_lui     = 6'h0f
    } opcode_t;

    // funct field of SPECIAL, bits 5:0
    typedef enum logic [5:0] {
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_slt  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_lui
    } alu_op_t;

    localparam word_t RESET_PC_DEFAULT = 32'h0000_0000;

endpackage

// File: logic/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage #(
    parameter tiny_mips_pkg::word_t RESET_PC = tiny_mips_pkg::RESET_PC_DEFAULT
) (
    input  logic                 aclk,
    input  logic                 arst_n,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output tiny_mips_pkg::word_t wb_adr,
    input  tiny_mips_pkg::word_t wb_dat_i,
    input  logic                 wb_ack,
    input  logic                 ds_allowin,
    input  logic                 br_taken,
    input  tiny_mips_pkg::word_t br_target,
    output logic                 fs_valid,
    output tiny_mips_pkg::word_t fs_pc,
    output tiny_mips_pkg::word_t fs_inst
);

    tiny_mips_pkg::word_t pc;
    logic                 discard;
    logic                 rd_start;
    logic                 rd_done;
    logic                 accept;

    // one read at a time, and only when the output register is free by then
    assign rd_start = !wb_cyc && (!fs_valid || ds_allowin);
    assign rd_done  = wb_cyc && wb_ack;
    // a word fetched before a redirect is dropped
    assign accept   = rd_done && !discard && !br_taken;

    assign wb_stb = wb_cyc;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wb_cyc   <= 1'b0;
            pc       <= RESET_PC;
            discard  <= 1'b0;
            fs_valid <= 1'b0;
        end else begin
            if (rd_start) begin
                wb_cyc <= 1'b1;
            end else if (rd_done) begin
                wb_cyc <= 1'b0;
            end

            if (br_taken) begin
                pc <= br_target;
            end else if (rd_done && !discard) begin
                pc <= pc + 32'd4;
            end

            if (rd_done) begin
                discard <= 1'b0;
            end else if (br_taken && (wb_cyc || rd_start)) begin
                discard <= 1'b1;
            end

            if (accept) begin
                fs_valid <= 1'b1;
            end else if (ds_allowin || br_taken) begin
                fs_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_start) begin
            wb_adr <= pc;
        end
        if (accept) begin
            fs_pc   <= wb_adr;
            fs_inst <= wb_dat_i;
        end
    end

    // classic cycle: address holds until the ack
    a_wb_adr_hold: assert property (
        @(posedge aclk) disable iff (!arst_n)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr)
    );

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic                      aclk,
    input  logic                      arst_n,
    input  logic                      fs_valid,
    input  tiny_mips_pkg::word_t      fs_pc,
    input  tiny_mips_pkg::word_t      fs_inst,
    output logic                      ds_allowin,
    output tiny_mips_pkg::reg_addr_t  rf_raddr1,
    output tiny_mips_pkg::reg_addr_t  rf_raddr2,
    input  tiny_mips_pkg::word_t      rf_rdata1,
    input  tiny_mips_pkg::word_t      rf_rdata2,
    input  logic                      es_fwd_valid,
    input  tiny_mips_pkg::reg_addr_t  es_fwd_dest,
    input  tiny_mips_pkg::word_t      es_fwd_data,
    input  logic                      ws_fwd_valid,
    input  tiny_mips_pkg::reg_addr_t  ws_fwd_dest,
    input  tiny_mips_pkg::word_t      ws_fwd_data,
    output logic                      br_taken,
    output tiny_mips_pkg::word_t      br_target,
    output logic                      ds_valid,
    output tiny_mips_pkg::word_t      ds_pc,
    output tiny_mips_pkg::alu_op_t    ds_alu_op,
    output tiny_mips_pkg::word_t      ds_src1,
    output tiny_mips_pkg::word_t      ds_src2,
    output tiny_mips_pkg::reg_addr_t  ds_dest
);

    tiny_mips_pkg::opcode_t    opcode;
    tiny_mips_pkg::funct_t     funct;
    tiny_mips_pkg::reg_addr_t  rs;
    tiny_mips_pkg::reg_addr_t  rt;
    tiny_mips_pkg::reg_addr_t  rd;
    logic [15:0]               imm;
    tiny_mips_pkg::word_t      imm_sext;
    tiny_mips_pkg::word_t      rs_value;
    tiny_mips_pkg::word_t      rt_value;
    tiny_mips_pkg::alu_op_t    alu_op;
    tiny_mips_pkg::word_t      src2;
    tiny_mips_pkg::reg_addr_t  dest;
    logic                      is_beq;
    logic                      is_bne;

    assign opcode   = tiny_mips_pkg::opcode_t'(fs_inst[31:26]);
    assign funct    = tiny_mips_pkg::funct_t'(fs_inst[5:0]);
    assign rs       = fs_inst[25:21];
    assign rt       = fs_inst[20:16];
    assign rd       = fs_inst[15:11];
    assign imm      = fs_inst[15:0];
    assign imm_sext = {{16{imm[15]}}, imm};

    assign rf_raddr1 = rs;
    assign rf_raddr2 = rt;

    // execute never stalls, so the decode register drains every cycle
    assign ds_allowin = 1'b1;

    // youngest producer wins: execute, then writeback, then the file
    always_comb begin
        rs_value = rf_rdata1;
        rt_value = rf_rdata2;
        if (ws_fwd_valid && ws_fwd_dest == rs) begin
            rs_value = ws_fwd_data;
        end
        if (ws_fwd_valid && ws_fwd_dest == rt) begin
            rt_value = ws_fwd_data;
        end
        if (es_fwd_valid && es_fwd_dest == rs) begin
            rs_value = es_fwd_data;
        end
        if (es_fwd_valid && es_fwd_dest == rt) begin
            rt_value = es_fwd_data;
        end
    end

    always_comb begin
        alu_op = tiny_mips_pkg::alu_add;
        src2   = rt_value;
        dest   = '0;
        is_beq = 1'b0;
        is_bne = 1'b0;
        case (opcode)
            tiny_mips_pkg::op_special: begin
                dest = rd;
                case (funct)
                    tiny_mips_pkg::fn_addu: alu_op = tiny_mips_pkg::alu_add;
                    tiny_mips_pkg::fn_subu: alu_op = tiny_mips_pkg::alu_sub;
                    tiny_mips_pkg::fn_and:  alu_op = tiny_mips_pkg::alu_and;
                    tiny_mips_pkg::fn_or:   alu_op = tiny_mips_pkg::alu_or;
                    tiny_mips_pkg::fn_slt:  alu_op = tiny_mips_pkg::alu_slt;
                    default:                dest   = '0;
                endcase
            end
            tiny_mips_pkg::op_addiu: begin
                src2 = imm_sext;
                dest = rt;
            end
            tiny_mips_pkg::op_lui: begin
                alu_op = tiny_mips_pkg::alu_lui;
                src2   = {16'h0000, imm};
                dest   = rt;
            end
            tiny_mips_pkg::op_beq: is_beq = 1'b1;
            tiny_mips_pkg::op_bne: is_bne = 1'b1;
            // anything else passes down as a no-op
            default: dest = '0;
        endcase
    end

    assign br_taken  = fs_valid && ((is_beq && rs_value == rt_value) ||
                                    (is_bne && rs_value != rt_value));
    assign br_target = fs_pc + 32'd4 + {imm_sext[29:0], 2'b00};

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            ds_valid <= 1'b0;
        end else begin
            ds_valid <= fs_valid && ds_allowin;
        end
    end

    always_ff @(posedge aclk) begin
        if (fs_valid && ds_allowin) begin
            ds_pc     <= fs_pc;
            ds_alu_op <= alu_op;
            ds_src1   <= rs_value;
            ds_src2   <= src2;
            ds_dest   <= dest;
        end
    end

    a_alu_op_known: assert property (
        @(posedge aclk) disable iff (!arst_n)
        ds_valid |-> !$isunknown(ds_alu_op)
    );

endmodule

// File: logic/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic                      aclk,
    input  logic                      arst_n,
    input  tiny_mips_pkg::reg_addr_t  raddr1,
    input  tiny_mips_pkg::reg_addr_t  raddr2,
    output tiny_mips_pkg::word_t      rdata1,
    output tiny_mips_pkg::word_t      rdata2,
    input  logic                      we,
    input  tiny_mips_pkg::reg_addr_t  waddr,
    input  tiny_mips_pkg::word_t      wdata
);

    tiny_mips_pkg::word_t regs [32];

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: logic/exe_stage.sv
`timescale 1ns/100ps

module exe_stage (
    input  logic                      aclk,
    input  logic                      arst_n,
    input  logic                      ds_valid,
    input  tiny_mips_pkg::word_t      ds_pc,
    input  tiny_mips_pkg::alu_op_t    ds_alu_op,
    input  tiny_mips_pkg::word_t      ds_src1,
    input  tiny_mips_pkg::word_t      ds_src2,
    input  tiny_mips_pkg::reg_addr_t  ds_dest,
    output logic                      es_fwd_valid,
    output tiny_mips_pkg::reg_addr_t  es_fwd_dest,
    output tiny_mips_pkg::word_t      es_fwd_data,
    output logic                      es_valid,
    output tiny_mips_pkg::word_t      es_pc,
    output tiny_mips_pkg::reg_addr_t  es_dest,
    output tiny_mips_pkg::word_t      es_result
);

    tiny_mips_pkg::word_t alu_result;

    always_comb begin
        case (ds_alu_op)
            tiny_mips_pkg::alu_add: alu_result = ds_src1 + ds_src2;
            tiny_mips_pkg::alu_sub: alu_result = ds_src1 - ds_src2;
            tiny_mips_pkg::alu_and: alu_result = ds_src1 & ds_src2;
            tiny_mips_pkg::alu_or:  alu_result = ds_src1 | ds_src2;
            tiny_mips_pkg::alu_slt: begin
                alu_result = {{(tiny_mips_pkg::XLEN-1){1'b0}},
                              $signed(ds_src1) < $signed(ds_src2)};
            end
            tiny_mips_pkg::alu_lui: alu_result = {ds_src2[15:0], 16'h0000};
            default:                alu_result = '0;
        endcase
    end

    // result is ready in this cycle, so decode can use it right away
    assign es_fwd_valid = ds_valid && (ds_dest != '0);
    assign es_fwd_dest  = ds_dest;
    assign es_fwd_data  = alu_result;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            es_valid <= 1'b0;
        end else begin
            es_valid <= ds_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (ds_valid) begin
            es_pc     <= ds_pc;
            es_dest   <= ds_dest;
            es_result <= alu_result;
        end
    end

    // r0 is never forwarded
    a_fwd_dest_nonzero: assert property (
        @(posedge aclk) disable iff (!arst_n)
        es_fwd_valid |-> es_fwd_dest != '0
    );

endmodule

// File: logic/wb_stage.sv
`timescale 1ns/100ps

module wb_stage (
    input  logic                      aclk,
    input  logic                      arst_n,
    input  logic                      es_valid,
    input  tiny_mips_pkg::word_t      es_pc,
    input  tiny_mips_pkg::reg_addr_t  es_dest,
    input  tiny_mips_pkg::word_t      es_result,
    output logic                      rf_we,
    output tiny_mips_pkg::reg_addr_t  rf_waddr,
    output tiny_mips_pkg::word_t      rf_wdata,
    output logic                      ws_fwd_valid,
    output tiny_mips_pkg::reg_addr_t  ws_fwd_dest,
    output tiny_mips_pkg::word_t      ws_fwd_data,
    output tiny_mips_pkg::word_t      debug_wb_pc,
    output logic                      debug_wb_rf_wen,
    output tiny_mips_pkg::reg_addr_t  debug_wb_rf_wnum,
    output tiny_mips_pkg::word_t      debug_wb_rf_wdata
);

    // branches, no-ops and r0 writes carry dest 0
    assign rf_we    = es_valid && (es_dest != '0);
    assign rf_waddr = es_dest;
    assign rf_wdata = es_result;

    // covers the value the file only takes at the coming edge
    assign ws_fwd_valid = rf_we;
    assign ws_fwd_dest  = es_dest;
    assign ws_fwd_data  = es_result;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            debug_wb_rf_wen <= 1'b0;
        end else begin
            debug_wb_rf_wen <= rf_we;
        end
    end

    always_ff @(posedge aclk) begin
        if (es_valid) begin
            debug_wb_pc       <= es_pc;
            debug_wb_rf_wnum  <= es_dest;
            debug_wb_rf_wdata <= es_result;
        end
    end

endmodule

// File: logic/tiny_mips_top.sv
`timescale 1ns/100ps

module tiny_mips_top #(
    parameter tiny_mips_pkg::word_t RESET_PC = tiny_mips_pkg::RESET_PC_DEFAULT
) (
    input  logic                      aclk,
    input  logic                      arst_n,
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output tiny_mips_pkg::word_t      wb_adr,
    input  tiny_mips_pkg::word_t      wb_dat_i,
    input  logic                      wb_ack,
    output tiny_mips_pkg::word_t      debug_wb_pc,
    output logic                      debug_wb_rf_wen,
    output tiny_mips_pkg::reg_addr_t  debug_wb_rf_wnum,
    output tiny_mips_pkg::word_t      debug_wb_rf_wdata
);

    // fetch and decode
    logic                      ds_allowin;
    logic                      br_taken;
    tiny_mips_pkg::word_t      br_target;
    logic                      fs_valid;
    tiny_mips_pkg::word_t      fs_pc;
    tiny_mips_pkg::word_t      fs_inst;
    tiny_mips_pkg::reg_addr_t  rf_raddr1;
    tiny_mips_pkg::reg_addr_t  rf_raddr2;
    tiny_mips_pkg::word_t      rf_rdata1;
    tiny_mips_pkg::word_t      rf_rdata2;

    // forwarding back into decode
    logic                      es_fwd_valid;
    tiny_mips_pkg::reg_addr_t  es_fwd_dest;
    tiny_mips_pkg::word_t      es_fwd_data;
    logic                      ws_fwd_valid;
    tiny_mips_pkg::reg_addr_t  ws_fwd_dest;
    tiny_mips_pkg::word_t      ws_fwd_data;

    // decode to execute to writeback
    logic                      ds_valid;
    tiny_mips_pkg::word_t      ds_pc;
    tiny_mips_pkg::alu_op_t    ds_alu_op;
    tiny_mips_pkg::word_t      ds_src1;
    tiny_mips_pkg::word_t      ds_src2;
    tiny_mips_pkg::reg_addr_t  ds_dest;
    logic                      es_valid;
    tiny_mips_pkg::word_t      es_pc;
    tiny_mips_pkg::reg_addr_t  es_dest;
    tiny_mips_pkg::word_t      es_result;
    logic                      rf_we;
    tiny_mips_pkg::reg_addr_t  rf_waddr;
    tiny_mips_pkg::word_t      rf_wdata;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (.*);

    decode_stage u_decode (.*);

    reg_file u_reg_file (
        .aclk   (aclk),
        .arst_n (arst_n),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    exe_stage u_exe (.*);

    wb_stage u_wb (.*);

endmodule

// File: testbench/tb_tiny_mips.sv
`timescale 1ns/100ps

module tb_tiny_mips;

    localparam int          MEM_WORDS   = 64;
    localparam int          MAX_WAIT    = 4;
    localparam int          MAX_EXP     = 64;
    localparam int          REF_STEPS   = 200;
    localparam int          RUN_TIMEOUT = 3000;
    localparam logic [31:0] SEED        = 32'hb376_c379;
    localparam logic [31:0] START_PC    = tiny_mips_pkg::RESET_PC_DEFAULT;

    // MIPS32 encodings
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] FN_ADDU    = 6'h21;
    localparam logic [5:0] FN_SUBU    = 6'h23;
    localparam logic [5:0] FN_AND     = 6'h24;
    localparam logic [5:0] FN_OR      = 6'h25;
    localparam logic [5:0] FN_SLT     = 6'h2a;

    logic        aclk;
    logic        arst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_i;
    logic        wb_ack;
    logic [31:0] debug_wb_pc;
    logic        debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] mem [MEM_WORDS];
    int          prog_len;

    // expected write-backs in program order
    logic [31:0] exp_pc   [MAX_EXP];
    logic [4:0]  exp_num  [MAX_EXP];
    logic [31:0] exp_data [MAX_EXP];
    int          exp_count;
    int          trace_idx;
    logic [31:0] loop_pc;
    int          loop_hits;
    logic        first_req_done;

    tiny_mips_top uut (
        .aclk              (aclk),
        .arst_n            (arst_n),
        .wb_cyc            (wb_cyc),
        .wb_stb            (wb_stb),
        .wb_adr            (wb_adr),
        .wb_dat_i          (wb_dat_i),
        .wb_ack            (wb_ack),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        aclk = 1'b0;
        forever begin
            #50 aclk = ~aclk;
        end
    end

    task automatic fail_run(input string msg);
        $display("=== FAIL ===");
        $display("%s", msg);
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [31:0] r_type_word(input logic [5:0] funct, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [4:0] rd);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [5:0] op, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic append_word(input logic [31:0] word);
        mem[prog_len] = word;
        prog_len = prog_len + 1;
    endtask

    task automatic load_program();
        // unused words carry an unknown opcode and their own byte address
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {6'h3f, 26'(i * 4)};
        end
        prog_len = 0;
        append_word(i_type_word(OP_ADDIU, 5'd0, 5'd1, 16'd5));
        append_word(i_type_word(OP_ADDIU, 5'd1, 5'd2, 16'hfffd));
        append_word(i_type_word(OP_LUI, 5'd0, 5'd3, 16'h8000));
        append_word(r_type_word(FN_ADDU, 5'd1, 5'd2, 5'd4));
        append_word(r_type_word(FN_SUBU, 5'd4, 5'd3, 5'd5));
        append_word(r_type_word(FN_AND, 5'd5, 5'd4, 5'd6));
        append_word(r_type_word(FN_OR, 5'd6, 5'd3, 5'd7));
        append_word(r_type_word(FN_SLT, 5'd7, 5'd1, 5'd8));
        append_word(r_type_word(FN_SLT, 5'd1, 5'd7, 5'd9));
        // write to r0 and read it back
        append_word(i_type_word(OP_ADDIU, 5'd1, 5'd0, 16'd9));
        append_word(r_type_word(FN_ADDU, 5'd0, 5'd8, 5'd10));
        // taken beq and bne each skip one word
        append_word(i_type_word(OP_BEQ, 5'd8, 5'd10, 16'd1));
        append_word(i_type_word(OP_ADDIU, 5'd0, 5'd11, 16'h0111));
        append_word(i_type_word(OP_BNE, 5'd9, 5'd8, 16'd1));
        append_word(i_type_word(OP_ADDIU, 5'd0, 5'd12, 16'h0222));
        // not-taken beq and bne fall through
        append_word(i_type_word(OP_BEQ, 5'd1, 5'd2, 16'd1));
        append_word(i_type_word(OP_ADDIU, 5'd10, 5'd13, 16'h7fff));
        append_word(i_type_word(OP_BNE, 5'd13, 5'd13, 16'd1));
        append_word(r_type_word(FN_OR, 5'd13, 5'd7, 5'd14));
        append_word(i_type_word(OP_BEQ, 5'd0, 5'd0, 16'hffff));
    endtask

    // instruction-level model without a delay slot
    task automatic run_reference();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_s;
        logic [31:0] next_pc;
        logic [31:0] value;
        logic [4:0]  dest;
        logic        done;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc = START_PC;
        done = 1'b0;
        exp_count = 0;
        for (int step = 0; step < REF_STEPS && !done; step++) begin
            inst    = mem[pc[7:2]];
            a       = regs[inst[25:21]];
            b       = regs[inst[20:16]];
            imm_s   = {{16{inst[15]}}, inst[15:0]};
            next_pc = pc + 32'd4;
            dest    = 5'd0;
            value   = '0;
            case (inst[31:26])
                OP_SPECIAL: begin
                    dest = inst[15:11];
                    case (inst[5:0])
                        FN_ADDU: value = a + b;
                        FN_SUBU: value = a - b;
                        FN_AND:  value = a & b;
                        FN_OR:   value = a | b;
                        FN_SLT:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: dest = 5'd0;
                    endcase
                end
                OP_ADDIU: begin
                    dest  = inst[20:16];
                    value = a + imm_s;
                end
                OP_LUI: begin
                    dest  = inst[20:16];
                    value = {inst[15:0], 16'h0000};
                end
                OP_BEQ: begin
                    if (a == b) begin
                        next_pc = pc + 32'd4 + (imm_s << 2);
                    end
                end
                OP_BNE: begin
                    if (a != b) begin
                        next_pc = pc + 32'd4 + (imm_s << 2);
                    end
                end
                default: dest = 5'd0;
            endcase
            if (dest != 5'd0) begin
                regs[dest]          = value;
                exp_pc[exp_count]   = pc;
                exp_num[exp_count]  = dest;
                exp_data[exp_count] = value;
                exp_count           = exp_count + 1;
            end
            if (next_pc == pc) begin
                done    = 1'b1;
                loop_pc = pc;
            end
            pc = next_pc;
        end
    endtask

    // Wishbone classic slave with 0 to MAX_WAIT wait states per read
    initial begin
        logic pending;
        int   wait_cnt;
        void'($urandom(SEED));
        pending  = 1'b0;
        wait_cnt = 0;
        forever begin
            @(negedge aclk);
            if (!wb_stb || wb_ack) begin
                wb_ack  = 1'b0;
                pending = 1'b0;
            end else begin
                if (!pending) begin
                    pending  = 1'b1;
                    wait_cnt = $urandom_range(MAX_WAIT, 0);
                end
                if (wait_cnt == 0) begin
                    wb_ack   = 1'b1;
                    wb_dat_i = mem[wb_adr[7:2]];
                end else begin
                    wait_cnt = wait_cnt - 1;
                end
            end
        end
    end

    always @(posedge aclk) begin
        if (!arst_n) begin
            trace_idx      <= 0;
            loop_hits      <= 0;
            first_req_done <= 1'b0;
        end else begin
            if (debug_wb_rf_wen) begin
                trace_idx <= trace_idx + 1;
            end
            if (wb_stb && wb_ack && wb_adr == loop_pc) begin
                loop_hits <= loop_hits + 1;
            end
            if (wb_stb) begin
                first_req_done <= 1'b1;
            end
        end
    end

    a_reset_quiet: assert property (
        @(posedge aclk) !arst_n |-> !wb_cyc && !debug_wb_rf_wen
    ) else fail_run($sformatf("Error: wb_cyc 0x%0h debug_wb_rf_wen 0x%0h in reset",
                              $sampled(wb_cyc), $sampled(debug_wb_rf_wen)));

    a_release_quiet: assert property (
        @(posedge aclk) $rose(arst_n) |-> !wb_cyc && !debug_wb_rf_wen
    ) else fail_run($sformatf("Error: wb_cyc 0x%0h debug_wb_rf_wen 0x%0h after reset",
                              $sampled(wb_cyc), $sampled(debug_wb_rf_wen)));

    a_first_adr: assert property (
        @(posedge aclk) disable iff (!arst_n)
        wb_stb && !first_req_done |-> wb_adr == START_PC
    ) else fail_run($sformatf("Error: wb_adr 0x%08h, expected 0x%08h",
                              $sampled(wb_adr), START_PC));

    a_stb_cyc_equal: assert property (
        @(posedge aclk) disable iff (!arst_n) wb_stb == wb_cyc
    ) else fail_run($sformatf("Error: wb_stb 0x%0h differs from wb_cyc 0x%0h",
                              $sampled(wb_stb), $sampled(wb_cyc)));

    a_request_hold: assert property (
        @(posedge aclk) disable iff (!arst_n)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr)
    ) else fail_run($sformatf("Error: wb_stb 0x%0h wb_adr 0x%08h changed before wb_ack",
                              $sampled(wb_stb), $sampled(wb_adr)));

    a_no_r0_write: assert property (
        @(posedge aclk) disable iff (!arst_n)
        debug_wb_rf_wen |-> debug_wb_rf_wnum != 5'd0
    ) else fail_run("Error: debug_wb_rf_wnum 0x00 with debug_wb_rf_wen 0x1");

    a_write_expected: assert property (
        @(posedge aclk) disable iff (!arst_n)
        debug_wb_rf_wen |-> trace_idx < exp_count
    ) else fail_run($sformatf("register write at pc 0x%08h after the last expected one",
                              $sampled(debug_wb_pc)));

    a_trace_pc: assert property (
        @(posedge aclk) disable iff (!arst_n)
        debug_wb_rf_wen && trace_idx < exp_count |-> debug_wb_pc == exp_pc[trace_idx]
    ) else fail_run($sformatf("Error: debug_wb_pc 0x%08h, expected 0x%08h",
                              $sampled(debug_wb_pc), exp_pc[$sampled(trace_idx)]));

    a_trace_num: assert property (
        @(posedge aclk) disable iff (!arst_n)
        debug_wb_rf_wen && trace_idx < exp_count |-> debug_wb_rf_wnum == exp_num[trace_idx]
    ) else fail_run($sformatf("Error: debug_wb_rf_wnum 0x%02h, expected 0x%02h",
                              $sampled(debug_wb_rf_wnum), exp_num[$sampled(trace_idx)]));

    a_trace_data: assert property (
        @(posedge aclk) disable iff (!arst_n)
        debug_wb_rf_wen && trace_idx < exp_count |-> debug_wb_rf_wdata == exp_data[trace_idx]
    ) else fail_run($sformatf("Error: debug_wb_rf_wdata 0x%08h, expected 0x%08h",
                              $sampled(debug_wb_rf_wdata), exp_data[$sampled(trace_idx)]));

    initial begin
        int cycles;
        arst_n   = 1'b0;
        wb_ack   = 1'b0;
        wb_dat_i = '0;
        loop_pc  = 32'hffff_ffff;
        load_program();
        run_reference();
        repeat (16) @(posedge aclk);
        @(negedge aclk);
        arst_n = 1'b1;
        // run until the self-loop spins with every write retired
        cycles = 0;
        while (!(trace_idx == exp_count && loop_hits >= 3) && cycles < RUN_TIMEOUT) begin
            @(negedge aclk);
            cycles = cycles + 1;
        end
        if (trace_idx == exp_count && loop_hits >= 3) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            fail_run($sformatf("timed out with %0d of %0d writes seen and %0d loop fetches",
                               trace_idx, exp_count, loop_hits));
        end
    end

endmodule

// File: tiny_mips.f
logic/tiny_mips_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/reg_file.sv
logic/exe_stage.sv
logic/wb_stage.sv
logic/tiny_mips_top.sv
testbench/tb_tiny_mips.sv

// File: Bender.yml
package:
  name: tiny_mips

sources:
  - logic/tiny_mips_pkg.sv
  - logic/fetch_stage.sv
  - logic/decode_stage.sv
  - logic/reg_file.sv
  - logic/exe_stage.sv
  - logic/wb_stage.sv
  - logic/tiny_mips_top.sv
  - target: simulation
    files:
      - testbench/tb_tiny_mips.sv
